//--- logic/zhxpu_pkg.sv
package zhxpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;
	typedef logic [7:0] mem_addr_t;

	localparam int imem_depth = 256;
	localparam int dmem_depth = 256;
	localparam int reg_count = 8;

	// apb byte addresses
	localparam logic [11:0] addr_ctrl = 12'h000;
	localparam logic [11:0] addr_status = 12'h004;
	localparam logic [11:0] reg_base = 12'h040;
	localparam logic [11:0] imem_base = 12'h400;
	localparam logic [11:0] dmem_base = 12'h800;

	// instruction bits 15:11
	typedef enum logic [4:0] {
		op_nop = 5'd0,
		op_li = 5'd1,
		op_addiu = 5'd2,
		op_addu = 5'd3,
		op_subu = 5'd4,
		op_and = 5'd5,
		op_or = 5'd6,
		op_slt = 5'd7,
		op_lw = 5'd8,
		op_sw = 5'd9,
		op_beqz = 5'd10,
		op_b = 5'd11,
		op_halt = 5'd12
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run = 2'd1,
		st_halted = 2'd2
	} run_state_e;

	typedef struct packed {
		opcode_e op;
		alu_op_e alu_op;
		reg_addr_t rx;
		reg_addr_t ry;
		reg_addr_t wr_addr;
		word_t imm;
		logic use_imm;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic branch_zero;
		logic jump;
		logic halt;
	} dec_t;

	typedef struct packed {
		logic start;
		logic imem_we;
		mem_addr_t imem_addr;
		word_t imem_wdata;
		reg_addr_t reg_addr;
		mem_addr_t dmem_addr;
	} dbg_req_t;

	typedef struct packed {
		run_state_e state;
		word_t pc;
		word_t reg_rdata;
		word_t dmem_rdata;
	} core_status_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

endpackage

//--- logic/alu.sv
`timescale 1ns/1ps

module alu(
	input zhxpu_pkg::alu_op_e op,
	input zhxpu_pkg::word_t a,
	input zhxpu_pkg::word_t b,
	output zhxpu_pkg::word_t res,
	output logic zero
);
	import zhxpu_pkg::*;

	logic less;

	// signed compare for slt
	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: res = a + b;
			alu_sub: res = a - b;
			alu_and: res = a & b;
			alu_or: res = a | b;
			alu_slt: res = {15'b0, less};
			default: res = b;
		endcase
	end

	// beqz tests the first operand
	assign zero = a == '0;

endmodule

//--- logic/decoder.sv
`timescale 1ns/1ps

module decoder(
	input zhxpu_pkg::word_t inst,
	output zhxpu_pkg::dec_t dec
);
	import zhxpu_pkg::*;

	opcode_e op;
	word_t imm8_s;
	word_t imm8_z;
	word_t imm5_z;
	word_t imm11_s;

	assign op = opcode_e'(inst[15:11]);

	assign imm8_s = {{8{inst[7]}}, inst[7:0]};
	assign imm8_z = {8'b0, inst[7:0]};
	assign imm5_z = {11'b0, inst[4:0]};
	assign imm11_s = {{5{inst[10]}}, inst[10:0]};

	always_comb begin
		dec = '0;
		dec.op = op;
		dec.alu_op = alu_pass_b;
		dec.rx = inst[10:8];
		dec.ry = inst[7:5];
		dec.wr_addr = inst[10:8];
		dec.imm = imm8_z;
		case (op)
			op_nop: ;
			op_li: begin
				dec.use_imm = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_addiu: begin
				dec.alu_op = alu_add;
				dec.imm = imm8_s;
				dec.use_imm = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_addu, op_subu, op_and, op_or, op_slt: begin
				case (op)
					op_addu: dec.alu_op = alu_add;
					op_subu: dec.alu_op = alu_sub;
					op_and: dec.alu_op = alu_and;
					op_or: dec.alu_op = alu_or;
					default: dec.alu_op = alu_slt;
				endcase
				dec.wr_addr = inst[4:2];
				dec.reg_write = 1'b1;
			end
			op_lw: begin
				// address is rx plus imm5, result lands in ry
				dec.alu_op = alu_add;
				dec.imm = imm5_z;
				dec.use_imm = 1'b1;
				dec.wr_addr = inst[7:5];
				dec.mem_read = 1'b1;
				dec.reg_write = 1'b1;
			end
			op_sw: begin
				dec.alu_op = alu_add;
				dec.imm = imm5_z;
				dec.use_imm = 1'b1;
				dec.mem_write = 1'b1;
			end
			op_beqz: begin
				dec.imm = imm8_s;
				dec.branch_zero = 1'b1;
			end
			op_b: begin
				dec.imm = imm11_s;
				dec.jump = 1'b1;
			end
			op_halt: dec.halt = 1'b1;
			// unused codes behave as nop
			default: dec.op = op_nop;
		endcase
	end

endmodule

//--- logic/register.sv
`timescale 1ns/1ps

module register(
	input logic clk,
	input logic rst_n,
	input logic we,
	input zhxpu_pkg::reg_addr_t waddr,
	input zhxpu_pkg::word_t wdata,
	input zhxpu_pkg::reg_addr_t raddr1,
	input zhxpu_pkg::reg_addr_t raddr2,
	input zhxpu_pkg::reg_addr_t dbg_addr,
	output zhxpu_pkg::word_t rdata1,
	output zhxpu_pkg::word_t rdata2,
	output zhxpu_pkg::word_t dbg_rdata
);
	import zhxpu_pkg::*;

	word_t regs [reg_count];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// execute reads and the debug port
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];
	assign dbg_rdata = regs[dbg_addr];

endmodule

//--- logic/inst_mem.sv
`timescale 1ns/1ps

module inst_mem(
	input logic clk,
	input logic we,
	input zhxpu_pkg::mem_addr_t waddr,
	input zhxpu_pkg::word_t wdata,
	input zhxpu_pkg::mem_addr_t raddr,
	output zhxpu_pkg::word_t rdata
);
	import zhxpu_pkg::*;

	word_t mem [imem_depth];

	// loader port
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// registered fetch read, old data on a same-address write
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- logic/core_pipe.sv
`timescale 1ns/1ps

module core_pipe(
	input logic clk,
	input logic rst_n,
	input zhxpu_pkg::dbg_req_t dbg,
	output zhxpu_pkg::core_status_t status
);
	import zhxpu_pkg::*;

	run_state_e state;
	word_t pc;
	word_t fetch_pc;
	logic fetch_valid;
	word_t imem_rdata;
	word_t exec_inst;
	dec_t dec;
	word_t reg_rdata1;
	word_t reg_rdata2;
	word_t dbg_reg_rdata;
	word_t alu_b;
	word_t alu_res;
	logic alu_zero;
	logic exec_en;
	logic redirect;
	word_t target;
	mem_addr_t mem_addr;
	word_t wb_data;
	word_t dmem [dmem_depth];

	// fetch register lives in the imem read port
	inst_mem __inst_mem(
		.clk(clk),
		.we(dbg.imem_we),
		.waddr(dbg.imem_addr),
		.wdata(dbg.imem_wdata),
		.raddr(pc[7:0]),
		.rdata(imem_rdata)
	);

	// bubble decodes as nop
	assign exec_inst = fetch_valid ? imem_rdata : word_t'(0);

	decoder __decoder(
		.inst(exec_inst),
		.dec(dec)
	);

	register __register(
		.clk(clk),
		.rst_n(rst_n),
		.we(exec_en & dec.reg_write),
		.waddr(dec.wr_addr),
		.wdata(wb_data),
		.raddr1(dec.rx),
		.raddr2(dec.ry),
		.dbg_addr(dbg.reg_addr),
		.rdata1(reg_rdata1),
		.rdata2(reg_rdata2),
		.dbg_rdata(dbg_reg_rdata)
	);

	assign alu_b = dec.use_imm ? dec.imm : reg_rdata2;

	alu __alu(
		.op(dec.alu_op),
		.a(reg_rdata1),
		.b(alu_b),
		.res(alu_res),
		.zero(alu_zero)
	);

	// a start pulse wins over the instruction in execute
	assign exec_en = fetch_valid && (state == st_run) && !dbg.start;
	assign redirect = exec_en && ((dec.branch_zero && alu_zero) || dec.jump);
	assign target = fetch_pc + 16'd1 + dec.imm;

	assign mem_addr = alu_res[7:0];
	assign wb_data = dec.mem_read ? dmem[mem_addr] : alu_res;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			pc <= '0;
			fetch_pc <= '0;
			fetch_valid <= 1'b0;
		end else if (dbg.start) begin
			state <= st_run;
			pc <= '0;
			fetch_valid <= 1'b0;
		end else if (state == st_run) begin
			if (exec_en && dec.halt) begin
				state <= st_halted;
				fetch_valid <= 1'b0;
			end else if (redirect) begin
				// drop the instruction fetched behind the branch
				pc <= target;
				fetch_valid <= 1'b0;
			end else begin
				pc <= pc + 16'd1;
				fetch_pc <= pc;
				fetch_valid <= 1'b1;
			end
		end
	end

	// data memory, cleared at reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < dmem_depth; i++)
				dmem[i] <= '0;
		end else if (exec_en && dec.mem_write) begin
			dmem[mem_addr] <= reg_rdata2;
		end
	end

	assign status.state = state;
	assign status.pc = pc;
	assign status.reg_rdata = dbg_reg_rdata;
	assign status.dmem_rdata = dmem[dbg.dmem_addr];

endmodule

//--- logic/debug_regs.sv
`timescale 1ns/1ps

module debug_regs(
	input logic clk,
	input logic rst_n,
	input zhxpu_pkg::apb_req_t apb_req,
	output zhxpu_pkg::apb_rsp_t apb_rsp,
	input zhxpu_pkg::core_status_t status,
	output zhxpu_pkg::dbg_req_t dbg
);
	import zhxpu_pkg::*;

	logic access;
	logic aligned;
	logic is_ctrl;
	logic is_status;
	logic is_reg;
	logic is_imem;
	logic is_dmem;
	logic mapped;
	logic bad;
	logic err;
	logic wr_ok;
	logic [31:0] rdata;
	logic start_q;
	logic imem_we_q;
	mem_addr_t imem_addr_q;
	word_t imem_wdata_q;

	assign access = apb_req.psel & apb_req.penable;
	assign aligned = apb_req.paddr[1:0] == 2'b00;

	// region decode
	assign is_ctrl = apb_req.paddr == addr_ctrl;
	assign is_status = apb_req.paddr == addr_status;
	assign is_reg = aligned && (apb_req.paddr[11:5] == reg_base[11:5]);
	assign is_imem = aligned && (apb_req.paddr[11:10] == imem_base[11:10]);
	assign is_dmem = aligned && (apb_req.paddr[11:10] == dmem_base[11:10]);
	assign mapped = is_ctrl | is_status | is_reg | is_imem | is_dmem;

	// imem is locked while the program runs
	assign bad = !mapped
		| (apb_req.pwrite & (is_status | is_reg | is_dmem))
		| (!apb_req.pwrite & is_imem)
		| (apb_req.pwrite & is_imem & (status.state == st_run));
	assign err = access & bad;
	assign wr_ok = access & apb_req.pwrite & !err;

	always_comb begin
		rdata = '0;
		if (is_status)
			rdata = {status.pc, 14'b0, status.state};
		else if (is_reg)
			rdata = {16'b0, status.reg_rdata};
		else if (is_dmem)
			rdata = {16'b0, status.dmem_rdata};
	end

	assign apb_rsp.prdata = rdata;
	assign apb_rsp.pready = 1'b1;
	assign apb_rsp.pslverr = err;

	// one-cycle pulses toward the core
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_q <= 1'b0;
			imem_we_q <= 1'b0;
		end else begin
			start_q <= wr_ok & is_ctrl & apb_req.pwdata[0];
			imem_we_q <= wr_ok & is_imem;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok && is_imem) begin
			imem_addr_q <= apb_req.paddr[9:2];
			imem_wdata_q <= apb_req.pwdata[15:0];
		end
	end

	assign dbg.start = start_q;
	assign dbg.imem_we = imem_we_q;
	assign dbg.imem_addr = imem_addr_q;
	assign dbg.imem_wdata = imem_wdata_q;
	// readback indexes come straight from the bus address
	assign dbg.reg_addr = apb_req.paddr[4:2];
	assign dbg.dmem_addr = apb_req.paddr[9:2];

endmodule

//--- logic/zhxpu.sv
`timescale 1ns/1ps

module zhxpu(
	input logic clk,
	input logic rst_n,
	input zhxpu_pkg::apb_req_t apb_req,
	output zhxpu_pkg::apb_rsp_t apb_rsp
);
	import zhxpu_pkg::*;

	// debug block steers the core
	dbg_req_t dbg;
	// core reports back state, pc and readback data
	core_status_t status;

	debug_regs __debug_regs(
		.clk(clk),
		.rst_n(rst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.status(status),
		.dbg(dbg)
	);

	core_pipe __core_pipe(
		.clk(clk),
		.rst_n(rst_n),
		.dbg(dbg),
		.status(status)
	);

endmodule

//--- verif/zhxpu_tb.sv
`timescale 1ns/1ps

module zhxpu_tb;
	import zhxpu_pkg::*;

	localparam int halt_poll_limit = 2000;
	localparam int ready_limit = 16;

	logic clk;
	logic rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	logic [31:0] seed;
	int mismatch_count;
	int other_count;
	word_t prog[$];

	zhxpu i_zhxpu(
		.clk(clk),
		.rst_n(rst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// instruction encoders
	function automatic word_t enc_imm(opcode_e op, reg_addr_t rx, logic [7:0] imm);
		return {op, rx, imm};
	endfunction

	function automatic word_t enc_alu(opcode_e op, reg_addr_t rx, reg_addr_t ry, reg_addr_t rz);
		return {op, rx, ry, rz, 2'b00};
	endfunction

	function automatic word_t enc_mem(opcode_e op, reg_addr_t rx, reg_addr_t ry, logic [4:0] imm5);
		return {op, rx, ry, imm5};
	endfunction

	function automatic word_t enc_jump(logic [10:0] off);
		return {op_b, off};
	endfunction

	function automatic word_t enc_halt();
		return {op_halt, 11'b0};
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string msg);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_state(input run_state_e got, input run_state_e exp, input string msg);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s got %s (%0d) expected %s", $time, msg, got.name(),
				got, exp.name());
		end
	endtask

	task automatic check_err(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			mismatch_count++;
			$display("mismatch at %0t: %s pslverr %b expected %b", $time, msg, got, exp);
		end
	endtask

	// setup cycle, then access cycle; response sampled mid access cycle
	task automatic apb_transfer(input logic is_write, input logic [11:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waits;
		waits = 0;
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= is_write;
		apb_req.paddr <= addr;
		apb_req.pwdata <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		@(negedge clk);
		while (!apb_rsp.pready && waits < ready_limit) begin
			@(negedge clk);
			waits++;
		end
		if (!apb_rsp.pready) begin
			other_count++;
			$display("apb transfer to %h got no pready within %0d cycles", addr, ready_limit);
		end
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge clk);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, 32'h0, data, err);
	endtask

	task automatic read_status(output run_state_e st, output word_t pc);
		logic [31:0] data;
		logic err;
		apb_read(addr_status, data, err);
		check_err(err, 1'b0, "status read");
		st = run_state_e'(data[1:0]);
		pc = data[31:16];
	endtask

	task automatic expect_reg(input reg_addr_t idx, input word_t exp, input string msg);
		logic [31:0] data;
		logic err;
		apb_read(reg_base + {7'b0, idx, 2'b00}, data, err);
		check_err(err, 1'b0, msg);
		check_word(data[15:0], exp, msg);
	endtask

	task automatic expect_dmem(input mem_addr_t addr, input word_t exp, input string msg);
		logic [31:0] data;
		logic err;
		apb_read(dmem_base + {2'b0, addr, 2'b00}, data, err);
		check_err(err, 1'b0, msg);
		check_word(data[15:0], exp, msg);
	endtask

	task automatic load_program();
		logic err;
		for (int i = 0; i < prog.size(); i++) begin
			apb_write(imem_base + 12'(4 * i), {16'b0, prog[i]}, err);
			check_err(err, 1'b0, $sformatf("imem load word %0d", i));
		end
	endtask

	task automatic start_core();
		logic err;
		apb_write(addr_ctrl, 32'h1, err);
		check_err(err, 1'b0, "start write");
	endtask

	task automatic wait_for_halt();
		run_state_e st;
		word_t pc;
		int polls;
		polls = 0;
		read_status(st, pc);
		while (st != st_halted && polls < halt_poll_limit) begin
			polls++;
			read_status(st, pc);
		end
		if (st != st_halted) begin
			other_count++;
			$display("core did not halt within %0d status polls", halt_poll_limit);
		end
	endtask

	task automatic run_until_halt();
		run_state_e st;
		word_t pc;
		start_core();
		wait_for_halt();
		read_status(st, pc);
		check_state(st, st_halted, "state at end of program");
	endtask

	task automatic test_reset();
		run_state_e st;
		word_t pc;
		logic [31:0] r;
		read_status(st, pc);
		check_state(st, st_idle, "state after reset");
		check_word(pc, 16'h0, "pc after reset");
		for (int i = 0; i < 8; i++)
			expect_reg(reg_addr_t'(i), 16'h0, $sformatf("r%0d after reset", i));
		for (int i = 0; i < 6; i++) begin
			r = next_rand();
			expect_dmem(r[7:0], 16'h0, $sformatf("dmem %h after reset", r[7:0]));
		end
	endtask

	task automatic test_alu();
		logic [31:0] r;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		word_t e1;
		word_t e2;
		word_t e4;
		r = next_rand();
		a = r[7:0];
		b = r[15:8];
		c = r[23:16];
		e1 = {8'h00, a};
		// addiu sign-extends its immediate
		e2 = {8'h00, b} + {{8{c[7]}}, c};
		e4 = e1 - e2;
		prog.delete();
		prog.push_back(enc_imm(op_li, 3'd1, a));
		prog.push_back(enc_imm(op_li, 3'd2, b));
		prog.push_back(enc_imm(op_addiu, 3'd2, c));
		prog.push_back(enc_alu(op_addu, 3'd1, 3'd2, 3'd3));
		prog.push_back(enc_alu(op_subu, 3'd1, 3'd2, 3'd4));
		prog.push_back(enc_alu(op_and, 3'd1, 3'd2, 3'd5));
		prog.push_back(enc_alu(op_or, 3'd1, 3'd2, 3'd6));
		prog.push_back(enc_alu(op_slt, 3'd1, 3'd2, 3'd7));
		prog.push_back(enc_alu(op_slt, 3'd4, 3'd1, 3'd0));
		prog.push_back(enc_halt());
		prog.push_back(enc_imm(op_li, 3'd1, ~a));
		load_program();
		run_until_halt();
		expect_reg(3'd1, e1, "alu r1 li");
		expect_reg(3'd2, e2, "alu r2 addiu");
		expect_reg(3'd3, e1 + e2, "alu r3 addu");
		expect_reg(3'd4, e4, "alu r4 subu");
		expect_reg(3'd5, e1 & e2, "alu r5 and");
		expect_reg(3'd6, e1 | e2, "alu r6 or");
		expect_reg(3'd7, ($signed(e1) < $signed(e2)) ? 16'h1 : 16'h0, "alu r7 slt");
		expect_reg(3'd0, ($signed(e4) < $signed(e1)) ? 16'h1 : 16'h0, "alu r0 slt");
	endtask

	task automatic test_memory();
		logic [31:0] r;
		logic [7:0] base;
		logic [7:0] v1;
		logic [4:0] off1;
		logic [4:0] off2;
		word_t ev1;
		word_t ev2;
		r = next_rand();
		base = {1'b0, r[6:0]};
		v1 = r[15:8];
		off1 = r[20:16];
		off2 = off1 ^ 5'h10;
		ev1 = {8'h00, v1};
		ev2 = 16'h0 - ev1;
		prog.delete();
		prog.push_back(enc_imm(op_li, 3'd0, 8'h00));
		prog.push_back(enc_imm(op_li, 3'd1, base));
		prog.push_back(enc_imm(op_li, 3'd2, v1));
		prog.push_back(enc_alu(op_subu, 3'd0, 3'd2, 3'd3));
		prog.push_back(enc_mem(op_sw, 3'd1, 3'd2, off1));
		prog.push_back(enc_mem(op_sw, 3'd1, 3'd3, off2));
		prog.push_back(enc_mem(op_lw, 3'd1, 3'd5, off1));
		prog.push_back(enc_mem(op_lw, 3'd1, 3'd6, off2));
		prog.push_back(enc_halt());
		load_program();
		run_until_halt();
		expect_dmem(base + {3'b0, off1}, ev1, "dmem first store");
		expect_dmem(base + {3'b0, off2}, ev2, "dmem second store");
		expect_reg(3'd5, ev1, "lw into r5");
		expect_reg(3'd6, ev2, "lw into r6");
	endtask

	task automatic test_branch();
		logic [31:0] r;
		logic [7:0] n;
		r = next_rand();
		n = {6'b0, r[1:0]} + 8'd2;
		prog.delete();
		prog.push_back(enc_imm(op_li, 3'd0, 8'h00));
		prog.push_back(enc_imm(op_li, 3'd1, n));
		prog.push_back(enc_imm(op_li, 3'd2, 8'h00));
		prog.push_back(enc_imm(op_li, 3'd6, 8'h00));
		prog.push_back(enc_imm(op_li, 3'd7, 8'h33));
		// taken, skips the failure mark at 6
		prog.push_back(enc_imm(op_beqz, 3'd0, 8'h01));
		prog.push_back(enc_imm(op_li, 3'd6, 8'hee));
		// not taken, r1 holds the loop count
		prog.push_back(enc_imm(op_beqz, 3'd1, 8'h01));
		prog.push_back(enc_imm(op_li, 3'd5, 8'h42));
		// loop body at 9
		prog.push_back(enc_imm(op_addiu, 3'd2, 8'h01));
		prog.push_back(enc_imm(op_addiu, 3'd1, 8'hff));
		prog.push_back(enc_imm(op_beqz, 3'd1, 8'h01));
		prog.push_back(enc_jump(11'h7fc));
		prog.push_back(enc_halt());
		prog.push_back(enc_imm(op_li, 3'd7, 8'h99));
		load_program();
		run_until_halt();
		expect_reg(3'd0, 16'h0000, "branch r0");
		expect_reg(3'd1, 16'h0000, "loop count left");
		expect_reg(3'd2, {8'h00, n}, "loop iterations");
		expect_reg(3'd5, 16'h0042, "fall through after untaken beqz");
		expect_reg(3'd6, 16'h0000, "skipped li");
		expect_reg(3'd7, 16'h0033, "li after halt");
	endtask

	task automatic test_restart();
		logic [31:0] r;
		logic [7:0] x;
		logic [7:0] y;
		r = next_rand();
		x = r[7:0];
		y = r[15:8];
		prog.delete();
		prog.push_back(enc_imm(op_li, 3'd0, x));
		prog.push_back(enc_imm(op_li, 3'd1, y));
		prog.push_back(enc_alu(op_addu, 3'd0, 3'd1, 3'd2));
		prog.push_back(enc_alu(op_subu, 3'd1, 3'd0, 3'd3));
		prog.push_back(enc_halt());
		load_program();
		run_until_halt();
		expect_reg(3'd2, {8'h00, x} + {8'h00, y}, "restart addu");
		expect_reg(3'd3, {8'h00, y} - {8'h00, x}, "restart subu");
	endtask

	task automatic test_errors();
		logic [31:0] data;
		logic err;
		run_state_e st;
		word_t pc;
		apb_read(12'h100, data, err);
		check_err(err, 1'b1, "unmapped read");
		apb_write(12'h300, 32'h1, err);
		check_err(err, 1'b1, "unmapped write");
		apb_write(addr_status, 32'h3, err);
		check_err(err, 1'b1, "status write");
		apb_read(imem_base, data, err);
		check_err(err, 1'b1, "imem read");
		// countdown long enough to hit it with a write
		prog.delete();
		prog.push_back(enc_imm(op_li, 3'd1, 8'd200));
		prog.push_back(enc_imm(op_li, 3'd3, 8'h00));
		prog.push_back(enc_imm(op_addiu, 3'd1, 8'hff));
		prog.push_back(enc_imm(op_beqz, 3'd1, 8'h01));
		prog.push_back(enc_jump(11'h7fd));
		prog.push_back(enc_imm(op_li, 3'd3, 8'h5a));
		prog.push_back(enc_halt());
		load_program();
		start_core();
		read_status(st, pc);
		check_state(st, st_run, "state while looping");
		apb_write(imem_base + 12'd20, {16'b0, enc_imm(op_li, 3'd3, 8'ha5)}, err);
		check_err(err, 1'b1, "imem write while running");
		wait_for_halt();
		read_status(st, pc);
		check_state(st, st_halted, "state after countdown");
		expect_reg(3'd1, 16'h0000, "countdown r1");
		expect_reg(3'd3, 16'h005a, "r3 after refused imem write");
	endtask

	initial begin
		seed = 32'hd6d8_0d93;
		mismatch_count = 0;
		other_count = 0;
		rst_n = 1'b0;
		apb_req = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		test_reset();
		test_alu();
		test_memory();
		test_branch();
		test_restart();
		test_errors();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- all.f
logic/zhxpu_pkg.sv
logic/alu.sv
logic/decoder.sv
logic/register.sv
logic/inst_mem.sv
logic/core_pipe.sv
logic/debug_regs.sv
logic/zhxpu.sv
verif/zhxpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the zhxpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module zhxpu_tb -Mdir obj_dir -f all.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vzhxpu_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST PASSED" "$log"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation did not pass, see $log"
exit 1
